// File: src/uncore_params.svh
`ifndef UNCORE_PARAMS_SVH
`define UNCORE_PARAMS_SVH

// Message field widths
`define UNC_PADDR_W 40
`define UNC_DATA_W 64
`define UNC_LCE_W 2
`define UNC_NUM_REQ 3

// Local view of the physical address
`define UNC_DID_W 3
`define UNC_DEV_LSB 20
`define UNC_DEV_W 4
`define UNC_PAD_W (`UNC_PADDR_W - `UNC_DID_W - `UNC_DEV_W - `UNC_DEV_LSB)

// Anything below this is a local device address
`define UNC_DRAM_BASE 40'h0080000000

`define UNC_BOOT_DEV 4'd0
`define UNC_HOST_DEV 4'd1
`define UNC_CFG_DEV 4'd2
`define UNC_CLINT_DEV 4'd3
`define UNC_CACHE_DEV 4'd4

`define UNC_MSIP_OFS 16'h0000
`define UNC_MTIMECMP_OFS 16'h4000
`define UNC_MTIME_OFS 16'hBFF8

`endif

// File: src/uncore_pkg.sv
`default_nettype none

`include "uncore_params.svh"

package uncore_pkg;

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'd0,
    e_mem_wr = 2'd1
  } mem_op_e;

  typedef struct packed
  {
    logic [`UNC_DID_W-1:0] domain;
    logic [`UNC_PAD_W-1:0] pad;
    logic [`UNC_DEV_W-1:0] dev;
    logic [`UNC_DEV_LSB-1:0] offset;
  } paddr_local_s;

  // Raw view for the DRAM base compare, local view for device decode
  typedef union packed
  {
    logic [`UNC_PADDR_W-1:0] raw;
    paddr_local_s loc;
  } paddr_u;

  typedef struct packed
  {
    mem_op_e op;
    logic [`UNC_LCE_W-1:0] lce_id;
    paddr_u addr;
    logic [`UNC_DATA_W-1:0] data;
  } mem_msg_s;

endpackage

`default_nettype wire

// File: src/uncore_target_if.sv
`timescale 1ns/100ps
`default_nettype none

interface uncore_target_if import uncore_pkg::*; ();

  // Command broadcast from dispatch
  mem_msg_s cmd_msg;
  logic     clint_cmd_v;
  logic     lb_cmd_v;
  logic     clint_ready;
  logic     lb_ready;

  // Responses toward collection
  mem_msg_s clint_resp;
  logic     clint_resp_v;
  mem_msg_s lb_resp;
  logic     lb_resp_v;
  logic     clint_yumi;
  logic     lb_yumi;

  modport dispatch (output cmd_msg, clint_cmd_v, lb_cmd_v, input clint_ready, lb_ready);

  modport clint (input cmd_msg, clint_cmd_v, clint_yumi,
                 output clint_ready, clint_resp, clint_resp_v);

  modport loopback (input cmd_msg, lb_cmd_v, lb_yumi, output lb_ready, lb_resp, lb_resp_v);

  modport collect (input clint_resp, clint_resp_v, lb_resp, lb_resp_v,
                   output clint_yumi, lb_yumi);

endinterface

`default_nettype wire

// File: src/msg_fifo2.sv
`timescale 1ns/100ps
`default_nettype none

module msg_fifo2
  import uncore_pkg::*;
  (  input  logic     clk_i
   , input  logic     arst_n_i

   , input  mem_msg_s data_i
   , input  logic     v_i
   , output logic     ready_o

   , output mem_msg_s data_o
   , output logic     v_o
   , input  logic     yumi_i
   );

  mem_msg_s slot_q [2];
  logic     wr_ptr_q;
  logic     rd_ptr_q;
  logic     full_q;
  logic     empty_q;
  logic     enq;
  logic     deq;

  assign enq = v_i & ~full_q;
  assign deq = yumi_i;

  assign ready_o = ~full_q;
  assign v_o     = ~empty_q;
  assign data_o  = slot_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= ~wr_ptr_q;
      if (deq)
        rd_ptr_q <= ~rd_ptr_q;
      // Occupancy only changes when exactly one side moves
      if (enq && !deq)
      begin
        empty_q <= 1'b0;
        full_q  <= (~wr_ptr_q == rd_ptr_q);
      end
      else if (deq && !enq)
      begin
        full_q  <= 1'b0;
        empty_q <= (~rd_ptr_q == wr_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      slot_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

// File: src/cmd_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module cmd_dispatch
  import uncore_pkg::*;
  (  input  mem_msg_s                 head_i [`UNC_NUM_REQ]
   , input  logic [`UNC_NUM_REQ-1:0]  head_v_i
   , output logic [`UNC_NUM_REQ-1:0]  head_yumi_o

   , output mem_msg_s                 io_cmd_o
   , output logic                     io_cmd_v_o
   , input  logic                     io_ready_i

   , output mem_msg_s                 mem_cmd_o
   , output logic                     mem_cmd_v_o
   , input  logic                     mem_ready_i

   , uncore_target_if.dispatch        tgt
   );

  logic [`UNC_LCE_W-1:0] sel_idx;
  mem_msg_s              head;
  logic                  all_ready;
  logic                  grant_v;
  logic                  is_local;
  logic                  is_io;
  logic                  is_clint;
  logic                  is_mem;
  logic                  is_lb;

  // Every target must be ready, so one blocked port stalls all grants
  assign all_ready = io_ready_i & mem_ready_i & tgt.clint_ready & tgt.lb_ready;

  // Highest index with a valid head wins
  always_comb
  begin
    sel_idx     = '0;
    head_yumi_o = '0;
    for (int i = 0; i < `UNC_NUM_REQ; i++)
    begin
      if (head_v_i[i])
        sel_idx = `UNC_LCE_W'(i);
    end
    if (all_ready && (|head_v_i))
      head_yumi_o[sel_idx] = 1'b1;
  end

  assign head    = head_i[sel_idx];
  assign grant_v = |head_yumi_o;

  assign is_local = (head.addr.raw < `UNC_DRAM_BASE);
  assign is_io    = (head.addr.loc.domain != '0)
                  | (is_local & ((head.addr.loc.dev == `UNC_BOOT_DEV)
                               | (head.addr.loc.dev == `UNC_HOST_DEV)));
  assign is_clint = ~is_io & is_local & (head.addr.loc.dev == `UNC_CLINT_DEV);
  assign is_mem   = ~is_io & (~is_local | (head.addr.loc.dev == `UNC_CACHE_DEV));
  // Config device and any unmapped local device
  assign is_lb    = ~is_io & ~is_clint & ~is_mem;

  assign io_cmd_o    = head;
  assign mem_cmd_o   = head;
  assign tgt.cmd_msg = head;

  assign io_cmd_v_o      = grant_v & is_io;
  assign mem_cmd_v_o     = grant_v & is_mem;
  assign tgt.clint_cmd_v = grant_v & is_clint;
  assign tgt.lb_cmd_v    = grant_v & is_lb;

endmodule

`default_nettype wire

// File: src/uncore_clint.sv
`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module uncore_clint
  import uncore_pkg::*;
  (  input  logic          clk_i
   , input  logic          arst_n_i

   , uncore_target_if.clint tgt

   , output logic          timer_irq_o
   , output logic          software_irq_o
   );

  mem_msg_s               resp_q;
  logic                   resp_v_q;
  logic                   msip_q;
  logic [`UNC_DATA_W-1:0] mtimecmp_q;
  logic [`UNC_DATA_W-1:0] mtime_q;
  logic                   accept;
  logic                   is_wr;
  logic [15:0]            ofs;
  logic [`UNC_DATA_W-1:0] rd_data;

  assign tgt.clint_ready = ~resp_v_q;
  assign accept          = tgt.clint_cmd_v & ~resp_v_q;
  assign is_wr           = (tgt.cmd_msg.op == e_mem_wr);
  assign ofs             = tgt.cmd_msg.addr.loc.offset[15:0];

  always_comb
  begin
    case (ofs)
      `UNC_MSIP_OFS:     rd_data = `UNC_DATA_W'(msip_q);
      `UNC_MTIMECMP_OFS: rd_data = mtimecmp_q;
      `UNC_MTIME_OFS:    rd_data = mtime_q;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_q   <= 1'b0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end
    else
    begin
      if (accept)
        resp_v_q <= 1'b1;
      else if (tgt.clint_yumi)
        resp_v_q <= 1'b0;

      if (accept && is_wr && (ofs == `UNC_MSIP_OFS))
        msip_q <= tgt.cmd_msg.data[0];
      if (accept && is_wr && (ofs == `UNC_MTIMECMP_OFS))
        mtimecmp_q <= tgt.cmd_msg.data;
      // Free-running counter unless software loads it
      if (accept && is_wr && (ofs == `UNC_MTIME_OFS))
        mtime_q <= tgt.cmd_msg.data;
      else
        mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.op     <= tgt.cmd_msg.op;
      resp_q.lce_id <= tgt.cmd_msg.lce_id;
      resp_q.addr   <= tgt.cmd_msg.addr;
      resp_q.data   <= is_wr ? '0 : rd_data;
    end
  end

  assign tgt.clint_resp   = resp_q;
  assign tgt.clint_resp_v = resp_v_q;

  assign timer_irq_o    = (mtime_q >= mtimecmp_q);
  assign software_irq_o = msip_q;

endmodule

`default_nettype wire

// File: src/cmd_loopback.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_loopback
  import uncore_pkg::*;
  (  input  logic             clk_i
   , input  logic             arst_n_i

   , uncore_target_if.loopback tgt
   );

  mem_msg_s resp_q;
  logic     resp_v_q;
  logic     accept;

  assign tgt.lb_ready = ~resp_v_q;
  assign accept       = tgt.lb_cmd_v & ~resp_v_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (tgt.lb_yumi)
      resp_v_q <= 1'b0;
  end

  // Header is echoed so the requester can retire the access
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q      <= tgt.cmd_msg;
      resp_q.data <= '0;
    end
  end

  assign tgt.lb_resp   = resp_q;
  assign tgt.lb_resp_v = resp_v_q;

endmodule

`default_nettype wire

// File: src/resp_collect.sv
`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module resp_collect
  import uncore_pkg::*;
  (  uncore_target_if.collect         tgt

   , input  mem_msg_s                 io_resp_i
   , input  logic                     io_resp_v_i
   , output logic                     io_resp_yumi_o

   , input  mem_msg_s                 mem_resp_i
   , input  logic                     mem_resp_v_i
   , output logic                     mem_resp_yumi_o

   , input  logic [`UNC_NUM_REQ-1:0]  fifo_ready_i
   , output mem_msg_s                 fifo_data_o
   , output logic [`UNC_NUM_REQ-1:0]  fifo_v_o
   );

  logic all_ready;
  logic sel_v;

  // Any full response FIFO holds off every source
  assign all_ready = &fifo_ready_i;

  always_comb
  begin
    tgt.lb_yumi     = 1'b0;
    mem_resp_yumi_o = 1'b0;
    io_resp_yumi_o  = 1'b0;
    tgt.clint_yumi  = 1'b0;
    fifo_data_o     = tgt.lb_resp;
    if (all_ready)
    begin
      if (tgt.lb_resp_v)
        tgt.lb_yumi = 1'b1;
      else if (mem_resp_v_i)
      begin
        mem_resp_yumi_o = 1'b1;
        fifo_data_o     = mem_resp_i;
      end
      else if (io_resp_v_i)
      begin
        io_resp_yumi_o = 1'b1;
        fifo_data_o    = io_resp_i;
      end
      else if (tgt.clint_resp_v)
      begin
        tgt.clint_yumi = 1'b1;
        fifo_data_o    = tgt.clint_resp;
      end
    end
  end

  assign sel_v = tgt.lb_yumi | mem_resp_yumi_o | io_resp_yumi_o | tgt.clint_yumi;

  // Steer to the requester that issued the command
  always_comb
  begin
    for (int i = 0; i < `UNC_NUM_REQ; i++)
      fifo_v_o[i] = sel_v & (fifo_data_o.lce_id == `UNC_LCE_W'(i));
  end

endmodule

`default_nettype wire

// File: src/uncore.sv
`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module uncore
  import uncore_pkg::*;
  (  input  logic     clk_i
   , input  logic     arst_n_i

   // Requesters, indexed by LCE id
   , input  mem_msg_s req_cmd_i       [`UNC_NUM_REQ]
   , input  logic     req_cmd_v_i     [`UNC_NUM_REQ]
   , output logic     req_cmd_ready_o [`UNC_NUM_REQ]
   , output mem_msg_s req_resp_o      [`UNC_NUM_REQ]
   , output logic     req_resp_v_o    [`UNC_NUM_REQ]
   , input  logic     req_resp_yumi_i [`UNC_NUM_REQ]

   , output mem_msg_s io_cmd_o
   , output logic     io_cmd_v_o
   , input  logic     io_cmd_ready_i
   , input  mem_msg_s io_resp_i
   , input  logic     io_resp_v_i
   , output logic     io_resp_yumi_o

   , output mem_msg_s mem_cmd_o
   , output logic     mem_cmd_v_o
   , input  logic     mem_cmd_ready_i
   , input  mem_msg_s mem_resp_i
   , input  logic     mem_resp_v_i
   , output logic     mem_resp_yumi_o

   , output logic     timer_irq_o
   , output logic     software_irq_o
   );

  mem_msg_s                cmd_head      [`UNC_NUM_REQ];
  logic [`UNC_NUM_REQ-1:0] cmd_head_v;
  logic [`UNC_NUM_REQ-1:0] cmd_head_yumi;
  mem_msg_s                resp_fifo_data;
  logic [`UNC_NUM_REQ-1:0] resp_fifo_v;
  logic [`UNC_NUM_REQ-1:0] resp_fifo_ready;

  uncore_target_if tgt_if ();

  for (genvar i = 0; i < `UNC_NUM_REQ; i++)
  begin : g_req
    msg_fifo2 u_cmd_fifo
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.data_i(req_cmd_i[i])
       ,.v_i(req_cmd_v_i[i])
       ,.ready_o(req_cmd_ready_o[i])
       ,.data_o(cmd_head[i])
       ,.v_o(cmd_head_v[i])
       ,.yumi_i(cmd_head_yumi[i])
       );

    msg_fifo2 u_resp_fifo
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.data_i(resp_fifo_data)
       ,.v_i(resp_fifo_v[i])
       ,.ready_o(resp_fifo_ready[i])
       ,.data_o(req_resp_o[i])
       ,.v_o(req_resp_v_o[i])
       ,.yumi_i(req_resp_yumi_i[i])
       );
  end

  cmd_dispatch u_dispatch
    (.head_i(cmd_head)
     ,.head_v_i(cmd_head_v)
     ,.head_yumi_o(cmd_head_yumi)
     ,.io_cmd_o(io_cmd_o)
     ,.io_cmd_v_o(io_cmd_v_o)
     ,.io_ready_i(io_cmd_ready_i)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_ready_i(mem_cmd_ready_i)
     ,.tgt(tgt_if)
     );

  uncore_clint u_clint
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.tgt(tgt_if)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  cmd_loopback u_loopback
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.tgt(tgt_if)
     );

  resp_collect u_collect
    (.tgt(tgt_if)
     ,.io_resp_i(io_resp_i)
     ,.io_resp_v_i(io_resp_v_i)
     ,.io_resp_yumi_o(io_resp_yumi_o)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.fifo_ready_i(resp_fifo_ready)
     ,.fifo_data_o(resp_fifo_data)
     ,.fifo_v_o(resp_fifo_v)
     );

endmodule

`default_nettype wire

// File: tb/tb_uncore.sv
`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module tb_uncore
  import uncore_pkg::*;
  ();

  localparam int NUM_CMDS    = 100;
  localparam int NUM_CLINT   = 12;
  localparam int CMD_TOTAL   = `UNC_NUM_REQ * NUM_CMDS + NUM_CLINT;
  localparam int WATCHDOG_NS = 20 * CMD_TOTAL * 20;
  localparam logic [63:0] DEV_MASK = 64'h5a5a5a5a5a5a5a5a;

  localparam logic [1:0] DST_IO    = 2'd0;
  localparam logic [1:0] DST_MEM   = 2'd1;
  localparam logic [1:0] DST_CLINT = 2'd2;
  localparam logic [1:0] DST_LB    = 2'd3;

  typedef struct packed
  {
    mem_msg_s    cmd;
    logic [1:0]  dst;
    logic [63:0] rdata;
    logic        chk;
  } txn_s;

  logic     clk = 1'b0;
  logic     arst_n;
  mem_msg_s req_cmd       [`UNC_NUM_REQ];
  logic     req_cmd_v     [`UNC_NUM_REQ];
  logic     req_cmd_ready [`UNC_NUM_REQ];
  mem_msg_s req_resp      [`UNC_NUM_REQ];
  logic     req_resp_v    [`UNC_NUM_REQ];
  logic     req_resp_yumi [`UNC_NUM_REQ];
  // Index 0 is the I/O device, index 1 is memory
  mem_msg_s dev_cmd       [2];
  logic     dev_cmd_v     [2];
  logic     dev_ready     [2];
  mem_msg_s dev_resp      [2];
  logic     dev_resp_v    [2];
  logic     dev_resp_yumi [2];
  logic     timer_irq;
  logic     software_irq;

  integer      seed;
  int          cycle;
  int          errors;
  int          checks;
  int          io_stall;
  logic        model_msip;
  logic [63:0] model_mtimecmp;
  logic [63:0] last_mtime [`UNC_NUM_REQ];
  txn_s        issue_q    [`UNC_NUM_REQ][$];
  txn_s        exp_q      [`UNC_NUM_REQ][$];
  mem_msg_s    dev_expect [2][$];
  mem_msg_s    dev_pend   [2][$];
  int          dev_due    [2][$];

  uncore UUT
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.req_cmd_i(req_cmd)
     ,.req_cmd_v_i(req_cmd_v)
     ,.req_cmd_ready_o(req_cmd_ready)
     ,.req_resp_o(req_resp)
     ,.req_resp_v_o(req_resp_v)
     ,.req_resp_yumi_i(req_resp_yumi)
     ,.io_cmd_o(dev_cmd[0])
     ,.io_cmd_v_o(dev_cmd_v[0])
     ,.io_cmd_ready_i(dev_ready[0])
     ,.io_resp_i(dev_resp[0])
     ,.io_resp_v_i(dev_resp_v[0])
     ,.io_resp_yumi_o(dev_resp_yumi[0])
     ,.mem_cmd_o(dev_cmd[1])
     ,.mem_cmd_v_o(dev_cmd_v[1])
     ,.mem_cmd_ready_i(dev_ready[1])
     ,.mem_resp_i(dev_resp[1])
     ,.mem_resp_v_i(dev_resp_v[1])
     ,.mem_resp_yumi_o(dev_resp_yumi[1])
     ,.timer_irq_o(timer_irq)
     ,.software_irq_o(software_irq)
     );

  always #10 clk = ~clk;

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic gen_random_txn(input int r, output txn_s t);
    logic [63:0] rnd;
    logic [3:0]  dev;
    int          sel;
    rnd = {$random(seed), $random(seed)};
    sel = $unsigned($random(seed)) % 6;
    t = '0;
    t.cmd.op     = rnd[63] ? e_mem_wr : e_mem_rd;
    t.cmd.lce_id = `UNC_LCE_W'(r);
    t.cmd.data   = {$random(seed), $random(seed)};
    t.chk        = 1'b1;
    case (sel)
      0:
      begin
        // Nonzero domain field
        t.cmd.addr.raw = rnd[39:0];
        if (rnd[39:37] == 3'b0)
          t.cmd.addr.raw[37] = 1'b1;
        t.dst = DST_IO;
      end
      1:
      begin
        t.cmd.addr.raw = {16'h0, rnd[40] ? `UNC_HOST_DEV : `UNC_BOOT_DEV, rnd[19:0]};
        t.dst = DST_IO;
      end
      2:
      begin
        t.cmd.addr.raw = {3'b0, rnd[36:0]};
        t.cmd.addr.raw[31] = 1'b1;
        t.dst = DST_MEM;
      end
      3:
      begin
        t.cmd.addr.raw = {16'h0, `UNC_CACHE_DEV, rnd[19:0]};
        t.dst = DST_MEM;
      end
      4:
      begin
        dev = rnd[23:20];
        if (dev <= `UNC_CACHE_DEV && dev != `UNC_CFG_DEV)
          dev = `UNC_CFG_DEV;
        t.cmd.addr.raw = {16'h0, dev, rnd[19:0]};
        t.dst = DST_LB;
      end
      default:
      begin
        t.dst = DST_CLINT;
        if (rnd[41])
        begin
          // mtime value is unknown, only its order is checked
          t.cmd.op       = e_mem_rd;
          t.cmd.addr.raw = {16'h0, `UNC_CLINT_DEV, 4'h0, `UNC_MTIME_OFS};
          t.chk          = 1'b0;
        end
        else
          t.cmd.addr.raw = {16'h0, `UNC_CLINT_DEV, rnd[19:16], 4'h8, rnd[11:0]};
      end
    endcase
    if (t.dst == DST_IO || t.dst == DST_MEM)
      t.rdata = {24'h0, t.cmd.addr.raw} ^ DEV_MASK;
  endtask

  task automatic take_response(input int r);
    mem_msg_s got;
    txn_s     t;
    int       idx;
    got = req_resp[r];
    idx = -1;
    check_value(got.lce_id, r, "response lce_id");
    for (int i = 0; i < exp_q[r].size(); i++)
    begin
      if (idx < 0 && exp_q[r][i].cmd.addr.raw == got.addr.raw)
        idx = i;
    end
    if (idx < 0)
    begin
      errors++;
      $display("Requester %0d received a response for address %h that it never sent",
               r, got.addr.raw);
    end
    else
    begin
      t = exp_q[r][idx];
      exp_q[r].delete(idx);
      check_value(got.op, t.cmd.op, "response op");
      if (t.chk)
        check_value(got.data, t.rdata, "response data");
      else if (got.data < last_mtime[r])
      begin
        errors++;
        $display("mtime read on requester %0d went backwards at %0t", r, $time);
      end
      else
        last_mtime[r] = got.data;
    end
  endtask

  task automatic take_dev_cmd(input int d);
    mem_msg_s got;
    mem_msg_s resp;
    int       idx;
    got = dev_cmd[d];
    idx = -1;
    for (int i = 0; i < dev_expect[d].size(); i++)
    begin
      if (idx < 0 && dev_expect[d][i] == got)
        idx = i;
    end
    if (idx < 0)
    begin
      errors++;
      $display("%s port received a command it should not see, address %h",
               (d == 0) ? "I/O" : "Memory", got.addr.raw);
    end
    else
      dev_expect[d].delete(idx);
    resp      = got;
    resp.data = {24'h0, got.addr.raw} ^ DEV_MASK;
    dev_pend[d].push_back(resp);
    dev_due[d].push_back(cycle + 1 + ($unsigned($random(seed)) % 8));
  endtask

  task automatic step_cycle();
    logic [`UNC_NUM_REQ-1:0] took;
    logic [1:0]              done;
    txn_s                    t;
    @(negedge clk);
    cycle++;
    took = '0;
    done = '0;
    for (int r = 0; r < `UNC_NUM_REQ; r++)
    begin
      if (req_cmd_v[r] && req_cmd_ready[r])
      begin
        t = issue_q[r].pop_front();
        exp_q[r].push_back(t);
        if (t.dst == DST_IO)
          dev_expect[0].push_back(t.cmd);
        else if (t.dst == DST_MEM)
          dev_expect[1].push_back(t.cmd);
        took[r] = 1'b1;
      end
      if (req_resp_v[r] && req_resp_yumi[r])
        take_response(r);
    end
    for (int d = 0; d < 2; d++)
    begin
      if (dev_cmd_v[d] && dev_ready[d])
        take_dev_cmd(d);
      if (dev_resp_v[d] && dev_resp_yumi[d])
      begin
        void'(dev_pend[d].pop_front());
        void'(dev_due[d].pop_front());
        done[d] = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    for (int r = 0; r < `UNC_NUM_REQ; r++)
    begin
      if (took[r])
        req_cmd_v[r] = 1'b0;
      if (!req_cmd_v[r] && issue_q[r].size() > 0 && ($random(seed) & 3) != 0)
      begin
        req_cmd[r]   = issue_q[r][0].cmd;
        req_cmd_v[r] = 1'b1;
      end
      req_resp_yumi[r] = req_resp_v[r] && (($random(seed) & 1) != 0);
    end
    for (int d = 0; d < 2; d++)
    begin
      if (done[d])
        dev_resp_v[d] = 1'b0;
      if (!dev_resp_v[d] && dev_pend[d].size() > 0 && cycle >= dev_due[d][0])
      begin
        dev_resp[d]   = dev_pend[d][0];
        dev_resp_v[d] = 1'b1;
      end
    end
    // I/O ready drops for random stretches
    if (io_stall > 0)
    begin
      io_stall--;
      dev_ready[0] = 1'b0;
    end
    else if ($unsigned($random(seed)) % 20 == 0)
    begin
      io_stall     = 4 + $unsigned($random(seed)) % 16;
      dev_ready[0] = 1'b0;
    end
    else
      dev_ready[0] = ($random(seed) & 3) != 0;
    dev_ready[1] = ($random(seed) & 3) != 0;
  endtask

  function automatic logic traffic_pending();
    logic busy;
    busy = 1'b0;
    for (int r = 0; r < `UNC_NUM_REQ; r++)
      busy |= (issue_q[r].size() > 0) || (exp_q[r].size() > 0);
    for (int d = 0; d < 2; d++)
      busy |= (dev_pend[d].size() > 0);
    return busy;
  endfunction

  // One CLINT access from requester 0, finished before the next one starts
  task automatic clint_access(input logic wr, input logic [15:0] ofs, input logic [63:0] wdata,
                              input logic [63:0] rdata, input logic chk);
    txn_s t;
    t              = '0;
    t.cmd.op       = wr ? e_mem_wr : e_mem_rd;
    t.cmd.addr.raw = {16'h0, `UNC_CLINT_DEV, 4'h0, ofs};
    t.cmd.data     = wdata;
    t.dst          = DST_CLINT;
    t.rdata        = wr ? 64'h0 : rdata;
    t.chk          = chk;
    issue_q[0].push_back(t);
    while (issue_q[0].size() > 0 || exp_q[0].size() > 0)
      step_cycle();
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t before all commands were answered", $time);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    txn_s t;
    seed     = 32'he22af52b;
    cycle    = 0;
    errors   = 0;
    checks   = 0;
    io_stall = 0;
    arst_n   = 1'b0;
    for (int r = 0; r < `UNC_NUM_REQ; r++)
    begin
      req_cmd[r]       = '0;
      req_cmd_v[r]     = 1'b0;
      req_resp_yumi[r] = 1'b0;
      last_mtime[r]    = '0;
    end
    for (int d = 0; d < 2; d++)
    begin
      dev_ready[d]  = 1'b0;
      dev_resp[d]   = '0;
      dev_resp_v[d] = 1'b0;
    end
    model_msip     = 1'b0;
    model_mtimecmp = '1;

    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    for (int r = 0; r < `UNC_NUM_REQ; r++)
      check_value(req_resp_v[r], 0, "response valid after reset");
    check_value(dev_cmd_v[0], 0, "io_cmd_v_o after reset");
    check_value(dev_cmd_v[1], 0, "mem_cmd_v_o after reset");
    check_value(timer_irq, 0, "timer_irq_o after reset");
    check_value(software_irq, 0, "software_irq_o after reset");

    for (int r = 0; r < `UNC_NUM_REQ; r++)
    begin
      for (int n = 0; n < NUM_CMDS; n++)
      begin
        gen_random_txn(r, t);
        issue_q[r].push_back(t);
      end
    end
    while (traffic_pending())
      step_cycle();

    model_msip = 1'b1;
    clint_access(1, `UNC_MSIP_OFS, 64'h1, 0, 1);
    check_value(software_irq, model_msip, "software_irq_o after msip write");
    clint_access(0, `UNC_MSIP_OFS, 0, {63'h0, model_msip}, 1);
    model_mtimecmp = {$random(seed), $random(seed)} | 64'h8000_0000_0000_0000;
    clint_access(1, `UNC_MTIMECMP_OFS, model_mtimecmp, 0, 1);
    clint_access(0, `UNC_MTIMECMP_OFS, 0, model_mtimecmp, 1);
    check_value(timer_irq, 0, "timer_irq_o with a far compare value");
    model_mtimecmp = '0;
    clint_access(1, `UNC_MTIMECMP_OFS, model_mtimecmp, 0, 1);
    check_value(timer_irq, 1, "timer_irq_o after mtimecmp write of 0");
    clint_access(0, `UNC_MTIMECMP_OFS, 0, model_mtimecmp, 1);
    model_mtimecmp = '1;
    clint_access(1, `UNC_MTIMECMP_OFS, model_mtimecmp, 0, 1);
    check_value(timer_irq, 0, "timer_irq_o after mtimecmp write of all ones");
    model_msip = 1'b0;
    clint_access(1, `UNC_MSIP_OFS, 64'hffff_ffff_ffff_fffe, 0, 1);
    check_value(software_irq, model_msip, "software_irq_o after msip clear");
    clint_access(0, `UNC_MSIP_OFS, 0, {63'h0, model_msip}, 1);
    clint_access(0, `UNC_MTIME_OFS, 0, 0, 0);
    clint_access(0, `UNC_MTIME_OFS, 0, 0, 0);

    for (int r = 0; r < `UNC_NUM_REQ; r++)
    begin
      if (exp_q[r].size() != 0)
      begin
        errors++;
        $display("Requester %0d still waits for %0d responses", r, exp_q[r].size());
      end
    end
    for (int d = 0; d < 2; d++)
    begin
      if (dev_expect[d].size() != 0)
      begin
        errors++;
        $display("%0d commands never reached the %s port", dev_expect[d].size(),
                 (d == 0) ? "I/O" : "memory");
      end
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/uncore_pkg.sv
src/uncore_target_if.sv
src/msg_fifo2.sv
src/cmd_dispatch.sv
src/uncore_clint.sv
src/cmd_loopback.sv
src/resp_collect.sv
src/uncore.sv
tb/tb_uncore.sv

// File: Makefile
SIM      := verilator
TOP      := tb_uncore
FILELIST := tb.f
FLAGS    := --binary --timing --timescale 1ns/100ps -Wno-fatal
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
